/* hdl/pcs_block_pkg.sv */
package pcs_block_pkg;

	//////////////////////////////
	// Field sizes
	//////////////////////////////

	localparam int OCTET_W    = 8;
	localparam int NUM_OCTETS = 8;
	localparam int CC_W       = 7;
	localparam int NUM_CODES  = 8;
	localparam int SH_W       = 2;
	localparam int R_TYPE_W   = 3;

	// Control view, block type sits in the low byte
	typedef struct packed {
		logic [NUM_CODES-1:0][CC_W-1:0] body;
		logic [OCTET_W-1:0]             block_type;
	} ctrl_view_t;

	// Same 64 bits, octet 0 lowest in the data view
	typedef union packed {
		logic [NUM_OCTETS-1:0][OCTET_W-1:0] data_view;
		ctrl_view_t                         ctrl_view;
	} block_payload_u;

	typedef struct packed {
		logic [SH_W-1:0] sync_header;
		block_payload_u  payload;
	} coded_block_t;

	//////////////////////////////
	// Sync headers and block types
	//////////////////////////////

	localparam logic [SH_W-1:0] SH_DATA = 2'b01;
	localparam logic [SH_W-1:0] SH_CTRL = 2'b10;

	localparam logic [OCTET_W-1:0] BT_CTRL    = 8'h1E;
	localparam logic [OCTET_W-1:0] BT_START   = 8'h78;
	localparam logic [OCTET_W-1:0] BT_ORDERED = 8'h4B;
	localparam logic [OCTET_W-1:0] BT_T0      = 8'h87;
	localparam logic [OCTET_W-1:0] BT_T1      = 8'h99;
	localparam logic [OCTET_W-1:0] BT_T2      = 8'hAA;
	localparam logic [OCTET_W-1:0] BT_T3      = 8'hB4;
	localparam logic [OCTET_W-1:0] BT_T4      = 8'hCC;
	localparam logic [OCTET_W-1:0] BT_T5      = 8'hD2;
	localparam logic [OCTET_W-1:0] BT_T6      = 8'hE1;
	localparam logic [OCTET_W-1:0] BT_T7      = 8'hFF;

	// 7-bit control codes
	localparam logic [CC_W-1:0] CC_IDLE  = 7'h00;
	localparam logic [CC_W-1:0] CC_ERROR = 7'h1E;

	// Receive block classes
	localparam logic [R_TYPE_W-1:0] RT_C = 3'd0;
	localparam logic [R_TYPE_W-1:0] RT_S = 3'd1;
	localparam logic [R_TYPE_W-1:0] RT_D = 3'd2;
	localparam logic [R_TYPE_W-1:0] RT_T = 3'd3;
	localparam logic [R_TYPE_W-1:0] RT_E = 3'd4;

endpackage

/* hdl/xgmii_pkg.sv */
package xgmii_pkg;

	//////////////////////////////
	// XGMII word layout
	//////////////////////////////

	localparam int XGMII_LANES = 8;
	localparam int LANE_W      = 8;

	// Lane 0 in the low byte, ctrl bit n for lane n
	typedef struct packed {
		logic [XGMII_LANES-1:0][LANE_W-1:0] data;
		logic [XGMII_LANES-1:0]             ctrl;
	} xgmii_word_t;

	//////////////////////////////
	// Control characters
	//////////////////////////////

	localparam logic [LANE_W-1:0] XC_IDLE  = 8'h07;
	localparam logic [LANE_W-1:0] XC_START = 8'hFB;
	localparam logic [LANE_W-1:0] XC_TERM  = 8'hFD;
	localparam logic [LANE_W-1:0] XC_ERROR = 8'hFE;
	localparam logic [LANE_W-1:0] XC_SEQ   = 8'h9C;

	// Whole-word patterns
	localparam xgmii_word_t XGMII_IDLE_WORD = '{
		data: {XGMII_LANES{XC_IDLE}},
		ctrl: {XGMII_LANES{1'b1}}
	};

	localparam xgmii_word_t XGMII_ERROR_WORD = '{
		data: {XGMII_LANES{XC_ERROR}},
		ctrl: {XGMII_LANES{1'b1}}
	};

endpackage

/* hdl/block_type_decoder.sv */
`timescale 1ns/1ps

module block_type_decoder
	import pcs_block_pkg::*;
(
	input  logic                tb_clock,
	input  logic                tb_reset,
	input  logic                enable,
	input  coded_block_t        rx_coded,
	output coded_block_t        blk,
	output logic [R_TYPE_W-1:0] blk_type,
	output logic                blk_valid
);

	ctrl_view_t          ctrl_fields;
	logic                codes_legal;
	logic                codes_have_error;
	logic [R_TYPE_W-1:0] type_next;

	assign ctrl_fields = rx_coded.payload.ctrl_view;

	//////////////////////////////
	// Control code scan
	//////////////////////////////

	// Only idle and error codes may appear in a 0x1E block
	always_comb begin
		codes_legal      = 1'b1;
		codes_have_error = 1'b0;
		for (int i = 0; i < NUM_CODES; i++) begin
			if (ctrl_fields.body[i] != CC_IDLE && ctrl_fields.body[i] != CC_ERROR)
				codes_legal = 1'b0;
			if (ctrl_fields.body[i] == CC_ERROR)
				codes_have_error = 1'b1;
		end
	end

	//////////////////////////////
	// Classification
	//////////////////////////////

	always_comb begin
		type_next = RT_E;
		case (rx_coded.sync_header)
			SH_DATA: type_next = RT_D;
			SH_CTRL: begin
				case (ctrl_fields.block_type)
					BT_CTRL: begin
						// An error code anywhere turns the block into E
						if (codes_legal && !codes_have_error)
							type_next = RT_C;
						else
							type_next = RT_E;
					end
					BT_ORDERED: type_next = RT_C;
					BT_START:   type_next = RT_S;
					BT_T0, BT_T1, BT_T2, BT_T3,
					BT_T4, BT_T5, BT_T6, BT_T7: type_next = RT_T;
					// Lane-4 variants land here too
					default: type_next = RT_E;
				endcase
			end
			default: type_next = RT_E;
		endcase
	end

	//////////////////////////////
	// Capture on strobe
	//////////////////////////////

	always_ff @(posedge tb_clock or posedge tb_reset) begin
		if (tb_reset) begin
			blk_valid <= 1'b0;
			blk_type  <= RT_E;
		end else begin
			blk_valid <= enable;
			if (enable)
				blk_type <= type_next;
		end
	end

	always_ff @(posedge tb_clock) begin
		if (enable)
			blk <= rx_coded;
	end

endmodule

/* hdl/rx_sequence_checker.sv */
`timescale 1ns/1ps

module rx_sequence_checker
	import pcs_block_pkg::*;
(
	input  logic                tb_clock,
	input  logic                tb_reset,
	input  logic [R_TYPE_W-1:0] blk_type,
	input  logic                blk_valid,
	output logic                seq_error
);

	typedef enum logic [1:0] {
		st_init_c,
		st_data,
		st_error
	} rx_state_e;

	rx_state_e state;
	rx_state_e state_next;
	logic      legal;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		state_next = state;
		legal      = 1'b1;
		case (state)
			// Between frames, also entered after a terminate
			st_init_c: begin
				case (blk_type)
					RT_C: state_next = st_init_c;
					RT_S: state_next = st_data;
					default: legal = 1'b0;
				endcase
			end

			// Inside a frame
			st_data: begin
				case (blk_type)
					RT_D: state_next = st_data;
					RT_T: state_next = st_init_c;
					default: legal = 1'b0;
				endcase
			end

			// Any valid type pulls the machine back out
			st_error: begin
				case (blk_type)
					RT_C: state_next = st_init_c;
					RT_T: state_next = st_init_c;
					RT_S: state_next = st_data;
					RT_D: state_next = st_data;
					default: state_next = st_error;
				endcase
			end

			default: legal = 1'b0;
		endcase

		if (!legal)
			state_next = st_error;
	end

	// Same cycle as blk_valid, so the mapper sees it with the block
	assign seq_error = blk_valid && !legal;

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge tb_clock or posedge tb_reset) begin
		if (tb_reset) begin
			state <= st_init_c;
		end else begin
			if (blk_valid)
				state <= state_next;
		end
	end

endmodule

/* hdl/block_to_xgmii.sv */
`timescale 1ns/1ps

module block_to_xgmii
	import pcs_block_pkg::*;
	import xgmii_pkg::*;
(
	input  logic                tb_clock,
	input  logic                tb_reset,
	input  coded_block_t        blk,
	input  logic [R_TYPE_W-1:0] blk_type,
	input  logic                blk_valid,
	input  logic                seq_error,
	output xgmii_word_t         rx_word,
	output logic [R_TYPE_W-1:0] rx_type,
	output logic                rx_valid
);

	logic [OCTET_W-1:0]                 block_type;
	logic [2:0]                         term_pos;
	logic [NUM_OCTETS-1:0][OCTET_W-1:0] term_data;
	xgmii_word_t                        word_next;

	assign block_type = blk.payload.ctrl_view.block_type;

	// Octets 1..k move down to lanes 0..k-1
	assign term_data = blk.payload.data_view >> OCTET_W;

	//////////////////////////////
	// Terminate position
	//////////////////////////////

	always_comb begin
		case (block_type)
			BT_T0: term_pos = 3'd0;
			BT_T1: term_pos = 3'd1;
			BT_T2: term_pos = 3'd2;
			BT_T3: term_pos = 3'd3;
			BT_T4: term_pos = 3'd4;
			BT_T5: term_pos = 3'd5;
			BT_T6: term_pos = 3'd6;
			default: term_pos = 3'd7;
		endcase
	end

	//////////////////////////////
	// Lane mapping
	//////////////////////////////

	always_comb begin
		word_next = XGMII_ERROR_WORD;
		case (blk_type)
			RT_D: begin
				word_next.data = blk.payload.data_view;
				word_next.ctrl = '0;
			end

			RT_C: begin
				if (block_type == BT_ORDERED) begin
					word_next.data[0] = XC_SEQ;
					for (int i = 1; i < 4; i++)
						word_next.data[i] = blk.payload.data_view[i];
					for (int i = 4; i < XGMII_LANES; i++)
						word_next.data[i] = XC_IDLE;
					word_next.ctrl = 8'hF1;
				end else begin
					word_next = XGMII_IDLE_WORD;
				end
			end

			RT_S: begin
				word_next.data[0] = XC_START;
				for (int i = 1; i < XGMII_LANES; i++)
					word_next.data[i] = blk.payload.data_view[i];
				word_next.ctrl = 8'h01;
			end

			RT_T: begin
				for (int i = 0; i < XGMII_LANES; i++) begin
					if (i < term_pos) begin
						word_next.data[i] = term_data[i];
						word_next.ctrl[i] = 1'b0;
					end else if (i == term_pos) begin
						word_next.data[i] = XC_TERM;
						word_next.ctrl[i] = 1'b1;
					end else begin
						word_next.data[i] = XC_IDLE;
						word_next.ctrl[i] = 1'b1;
					end
				end
			end

			default: word_next = XGMII_ERROR_WORD;
		endcase

		// Sequence violation overrides whatever the block held
		if (seq_error)
			word_next = XGMII_ERROR_WORD;
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge tb_clock or posedge tb_reset) begin
		if (tb_reset) begin
			rx_valid <= 1'b0;
			rx_word  <= XGMII_ERROR_WORD;
			rx_type  <= RT_E;
		end else begin
			rx_valid <= blk_valid;
			if (blk_valid) begin
				rx_word <= word_next;
				rx_type <= blk_type;
			end
		end
	end

endmodule

/* hdl/pcs_rx_decode.sv */
`timescale 1ns/1ps

module pcs_rx_decode
	import pcs_block_pkg::*;
	import xgmii_pkg::*;
(
	input  logic                tb_clock,
	input  logic                tb_reset,
	input  logic                enable,
	input  coded_block_t        rx_coded,
	output xgmii_word_t         rx_word,
	output logic [R_TYPE_W-1:0] rx_type,
	output logic                rx_valid
);

	coded_block_t        blk;
	logic [R_TYPE_W-1:0] blk_type;
	logic                blk_valid;
	logic                seq_error;

	// Stage 1, capture and classify
	block_type_decoder u_block_type_decoder (
		.tb_clock  (tb_clock),
		.tb_reset  (tb_reset),
		.enable    (enable),
		.rx_coded  (rx_coded),
		.blk       (blk),
		.blk_type  (blk_type),
		.blk_valid (blk_valid)
	);

	rx_sequence_checker u_rx_sequence_checker (
		.tb_clock  (tb_clock),
		.tb_reset  (tb_reset),
		.blk_type  (blk_type),
		.blk_valid (blk_valid),
		.seq_error (seq_error)
	);

	// Stage 2, lane mapping
	block_to_xgmii u_block_to_xgmii (
		.tb_clock  (tb_clock),
		.tb_reset  (tb_reset),
		.blk       (blk),
		.blk_type  (blk_type),
		.blk_valid (blk_valid),
		.seq_error (seq_error),
		.rx_word   (rx_word),
		.rx_type   (rx_type),
		.rx_valid  (rx_valid)
	);

endmodule

/* testbench/pcs_rx_decode_chk.sv */
`timescale 1ns/1ps

module pcs_rx_decode_chk
	import pcs_block_pkg::*;
	import xgmii_pkg::*;
(
	input logic                tb_clock,
	input logic                tb_reset,
	input logic                enable,
	input xgmii_word_t         rx_word,
	input logic [R_TYPE_W-1:0] rx_type,
	input logic                rx_valid
);

	int error_count = 0;

	//////////////////////////////
	// Pipeline latency
	//////////////////////////////

	// Two register stages between strobe and output
	a_valid_after_enable: assert property (@(posedge tb_clock) disable iff (tb_reset)
		enable |-> ##2 rx_valid)
		else begin
			error_count++;
			$error("rx_valid missing two cycles after enable");
		end

	a_valid_has_cause: assert property (@(posedge tb_clock) disable iff (tb_reset)
		rx_valid |-> $past(enable, 2))
		else begin
			error_count++;
			$error("rx_valid without an enable two cycles earlier");
		end

	a_quiet_in_reset: assert property (@(posedge tb_clock)
		tb_reset |-> !rx_valid)
		else begin
			error_count++;
			$error("rx_valid high during reset");
		end

	// Error type always carries the error word
	a_error_word: assert property (@(posedge tb_clock)
		(rx_type == RT_E) |-> (rx_word == XGMII_ERROR_WORD))
		else begin
			error_count++;
			$error("rx_type is E but rx_word is not the error word");
		end

endmodule

/* testbench/tb_pcs_rx_decode.sv */
`timescale 1ns/1ps

module tb_pcs_rx_decode
	import pcs_block_pkg::*;
	import xgmii_pkg::*;
();

	typedef struct packed {
		coded_block_t        blk;
		logic [R_TYPE_W-1:0] exp_type;
		xgmii_word_t         exp_word;
		logic [1:0]          gap;
		logic                reset_before;
	} stim_row_t;

	typedef enum logic [1:0] {
		m_init_c,
		m_data,
		m_error
	} model_state_e;

	localparam logic [7:0] TERM_TYPES [8] = '{BT_T0, BT_T1, BT_T2, BT_T3,
		BT_T4, BT_T5, BT_T6, BT_T7};
	localparam logic [7:0] BAD_TYPES [5] = '{8'h33, 8'h66, 8'h55, 8'h2D, 8'h00};
	localparam int RESET_CYCLES = 8;
	localparam int MARGIN       = 50;

	logic                tb_clock;
	logic                tb_reset;
	logic                enable;
	coded_block_t        rx_coded;
	xgmii_word_t         rx_word;
	logic [R_TYPE_W-1:0] rx_type;
	logic                rx_valid;

	stim_row_t    rows[$];
	stim_row_t    exp_q[$];
	stim_row_t    expected;
	model_state_e model_state;
	logic [15:0]  lfsr_state;
	int           cycle_count = 0;
	int           cycle_limit = 100000;
	int           blocks_checked = 0;

	pcs_rx_decode dut (
		.tb_clock (tb_clock),
		.tb_reset (tb_reset),
		.enable   (enable),
		.rx_coded (rx_coded),
		.rx_word  (rx_word),
		.rx_type  (rx_type),
		.rx_valid (rx_valid)
	);

	bind pcs_rx_decode pcs_rx_decode_chk u_chk (
		.tb_clock (tb_clock),
		.tb_reset (tb_reset),
		.enable   (enable),
		.rx_word  (rx_word),
		.rx_type  (rx_type),
		.rx_valid (rx_valid)
	);

	always #4 tb_clock = ~tb_clock;

	//////////////////////////////
	// Random octets and gaps
	//////////////////////////////

	// 16-bit Fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [1:0] random_gap();
		logic [7:0] v;
		v = take_bits(2);
		return (v[1:0] == 2'd3) ? 2'd2 : v[1:0];
	endfunction

	// Block type in octet 0 unless it is a data block
	function automatic coded_block_t random_block(input logic [1:0] sh, input logic [7:0] bt);
		logic [63:0] p;
		for (int i = 0; i < 8; i++)
			p[8*i +: 8] = take_bits(8);
		if (sh != SH_DATA)
			p[7:0] = bt;
		return {sh, p};
	endfunction

	function automatic coded_block_t ctrl_block(input logic [6:0] lane3_code);
		logic [55:0] body;
		body = {8{CC_IDLE}};
		body[3*7 +: 7] = lane3_code;
		return {SH_CTRL, body, BT_CTRL};
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [R_TYPE_W-1:0] classify(input coded_block_t b);
		logic [63:0] p;
		logic        all_idle;
		p = b.payload;
		all_idle = 1'b1;
		for (int i = 0; i < 8; i++)
			if (p[8 + 7*i +: 7] != CC_IDLE)
				all_idle = 1'b0;
		if (b.sync_header == SH_DATA)
			return RT_D;
		if (b.sync_header != SH_CTRL)
			return RT_E;
		if (p[7:0] == BT_CTRL)
			return all_idle ? RT_C : RT_E;
		if (p[7:0] == BT_ORDERED)
			return RT_C;
		if (p[7:0] == BT_START)
			return RT_S;
		for (int i = 0; i < 8; i++)
			if (TERM_TYPES[i] == p[7:0])
				return RT_T;
		return RT_E;
	endfunction

	function automatic xgmii_word_t expected_word(input coded_block_t b,
		input logic [R_TYPE_W-1:0] t, input logic seq_err);
		logic [63:0] p;
		xgmii_word_t w;
		int          k;
		p = b.payload;
		w.data = {8{XC_ERROR}};
		w.ctrl = 8'hFF;
		k = 0;
		for (int i = 0; i < 8; i++)
			if (TERM_TYPES[i] == p[7:0])
				k = i;
		if (seq_err || t == RT_E)
			return w;
		case (t)
			RT_D: begin
				w.data = p;
				w.ctrl = 8'h00;
			end
			RT_C: begin
				if (p[7:0] == BT_ORDERED) begin
					w.data = {{4{XC_IDLE}}, p[31:8], XC_SEQ};
					w.ctrl = 8'hF1;
				end else begin
					w.data = {8{XC_IDLE}};
					w.ctrl = 8'hFF;
				end
			end
			RT_S: begin
				w.data = {p[63:8], XC_START};
				w.ctrl = 8'h01;
			end
			RT_T: begin
				for (int i = 0; i < 8; i++) begin
					w.data[i] = (i < k) ? p[8*(i+1) +: 8] : ((i == k) ? XC_TERM : XC_IDLE);
					w.ctrl[i] = (i >= k);
				end
			end
			default: ;
		endcase
		return w;
	endfunction

	task automatic advance_model(input logic [R_TYPE_W-1:0] t, output logic seq_err);
		seq_err = 1'b0;
		case (model_state)
			m_init_c: begin
				if (t == RT_S)
					model_state = m_data;
				else if (t != RT_C)
					seq_err = 1'b1;
			end
			m_data: begin
				if (t == RT_T)
					model_state = m_init_c;
				else if (t != RT_D)
					seq_err = 1'b1;
			end
			default: begin
				if (t == RT_C || t == RT_T)
					model_state = m_init_c;
				else if (t == RT_S || t == RT_D)
					model_state = m_data;
			end
		endcase
		if (seq_err)
			model_state = m_error;
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic add_row(input coded_block_t b, input logic [1:0] gap, input logic reset_before);
		stim_row_t r;
		logic      seq_err;
		if (reset_before)
			model_state = m_init_c;
		r.blk = b;
		r.exp_type = classify(b);
		advance_model(r.exp_type, seq_err);
		r.exp_word = expected_word(b, r.exp_type, seq_err);
		r.gap = gap;
		r.reset_before = reset_before;
		rows.push_back(r);
	endtask

	// Start, some data, then the given terminate; gap 3 means random
	task automatic add_frame(input logic [7:0] term, input int n_data, input logic [1:0] gap);
		add_row(random_block(SH_CTRL, BT_START), (gap == 3) ? random_gap() : gap, 1'b0);
		for (int i = 0; i < n_data; i++)
			add_row(random_block(SH_DATA, 8'h00), (gap == 3) ? random_gap() : gap, 1'b0);
		add_row(random_block(SH_CTRL, term), (gap == 3) ? random_gap() : gap, 1'b0);
	endtask

	task automatic build_table();
		model_state = m_init_c;
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		for (int k = 0; k < 8; k++) begin
			add_frame(TERM_TYPES[k], 2, 2'd3);
			add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		end
		// Ordered sets
		add_row(random_block(SH_CTRL, BT_ORDERED), random_gap(), 1'b0);
		add_row(random_block(SH_CTRL, BT_ORDERED), random_gap(), 1'b0);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		// Malformed blocks
		add_row(random_block(2'b00, BT_CTRL), random_gap(), 1'b0);
		add_row(random_block(2'b11, BT_START), random_gap(), 1'b0);
		foreach (BAD_TYPES[i])
			add_row(random_block(SH_CTRL, BAD_TYPES[i]), random_gap(), 1'b0);
		add_row(ctrl_block(CC_ERROR), random_gap(), 1'b0);
		add_row(ctrl_block(7'h2D), random_gap(), 1'b0);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		// Sequence violations and recovery
		add_row(random_block(SH_DATA, 8'h00), random_gap(), 1'b0);
		add_row(random_block(SH_CTRL, BT_START), random_gap(), 1'b0);
		add_row(random_block(SH_DATA, 8'h00), random_gap(), 1'b0);
		add_frame(BT_T5, 1, 2'd3);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		add_row(random_block(SH_CTRL, BT_START), random_gap(), 1'b0);
		add_row(random_block(SH_DATA, 8'h00), random_gap(), 1'b0);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		add_frame(BT_T2, 1, 2'd3);
		// Back to back
		add_row(ctrl_block(CC_IDLE), 2'd0, 1'b0);
		add_frame(BT_T3, 4, 2'd0);
		add_row(ctrl_block(CC_IDLE), 2'd0, 1'b0);
		add_row(ctrl_block(CC_IDLE), 2'd0, 1'b0);
		// Reset inside a frame
		add_row(random_block(SH_CTRL, BT_START), random_gap(), 1'b0);
		add_row(random_block(SH_DATA, 8'h00), random_gap(), 1'b0);
		add_row(random_block(SH_DATA, 8'h00), random_gap(), 1'b1);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
		add_frame(BT_T6, 1, 2'd3);
		add_row(ctrl_block(CC_IDLE), random_gap(), 1'b0);
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic compare_word(input xgmii_word_t got, input xgmii_word_t exp);
		if (got !== exp) begin
			$display("FAIL rx_word: got 0x%h expected 0x%h (block %0d)", got, exp, blocks_checked);
			$display("** FAIL **");
			$fatal(1, "rx_word mismatch");
		end
	endtask

	task automatic compare_type(input logic [R_TYPE_W-1:0] got, input logic [R_TYPE_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL rx_type: got 0x%h expected 0x%h (block %0d)", got, exp, blocks_checked);
			$display("** FAIL **");
			$fatal(1, "rx_type mismatch");
		end
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge tb_clock) begin
		if (!tb_reset && rx_valid) begin
			if (exp_q.size() == 0) begin
				$display("rx_valid pulsed while no block was expected");
				$display("** FAIL **");
				$fatal(1, "unexpected output");
			end else begin
				expected = exp_q.pop_front();
				compare_type(rx_type, expected.exp_type);
				compare_word(rx_word, expected.exp_word);
				blocks_checked++;
			end
		end
	end

	// Assertion failures in the bound checker
	always @(negedge tb_clock) begin
		if (dut.u_chk.error_count != 0) begin
			$display("An assertion in the bound checker failed");
			$display("** FAIL **");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge tb_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles with %0d blocks pending", cycle_count, exp_q.size());
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	task automatic drain();
		@(posedge tb_clock);
		enable <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge tb_clock);
	endtask

	task automatic pulse_reset();
		drain();
		tb_reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge tb_clock);
		tb_reset <= 1'b0;
	endtask

	initial begin
		tb_clock = 1'b0;
		tb_reset = 1'b1;
		enable = 1'b0;
		rx_coded = '0;
		lfsr_state = 16'd42;
		build_table();
		cycle_limit = 2 * RESET_CYCLES + MARGIN;
		foreach (rows[i])
			cycle_limit += 1 + rows[i].gap + (rows[i].reset_before ? RESET_CYCLES + 4 : 0);
		repeat (RESET_CYCLES) @(posedge tb_clock);
		tb_reset <= 1'b0;
		foreach (rows[i]) begin
			if (rows[i].reset_before)
				pulse_reset();
			@(posedge tb_clock);
			enable <= 1'b1;
			rx_coded <= rows[i].blk;
			exp_q.push_back(rows[i]);
			repeat (rows[i].gap) begin
				@(posedge tb_clock);
				enable <= 1'b0;
			end
		end
		@(posedge tb_clock);
		enable <= 1'b0;
		// Two-cycle latency, so the last block is out well before this
		repeat (4) @(posedge tb_clock);
		if (exp_q.size() != 0 || blocks_checked != rows.size()) begin
			$display("Only %0d of %0d blocks came out", blocks_checked, rows.size());
			$display("** FAIL **");
			$fatal(1, "missing output");
		end else if (dut.u_chk.error_count != 0) begin
			$display("%0d assertion failures in the bound checker", dut.u_chk.error_count);
			$display("** FAIL **");
			$fatal(1, "assertion failure");
		end else begin
			$display("%0d blocks checked", blocks_checked);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

/* flist.f */
hdl/pcs_block_pkg.sv
hdl/xgmii_pkg.sv
hdl/block_type_decoder.sv
hdl/rx_sequence_checker.sv
hdl/block_to_xgmii.sv
hdl/pcs_rx_decode.sv
testbench/pcs_rx_decode_chk.sv
testbench/tb_pcs_rx_decode.sv

/* Bender.yml */
package:
  name: pcs_rx_decode

sources:
  # Packages first, then the pipeline stages and the top level
  - files:
      - hdl/pcs_block_pkg.sv
      - hdl/xgmii_pkg.sv
      - hdl/block_type_decoder.sv
      - hdl/rx_sequence_checker.sv
      - hdl/block_to_xgmii.sv
      - hdl/pcs_rx_decode.sv

  # Testbench, with the bound assertion module ahead of the top
  - target: test
    files:
      - testbench/pcs_rx_decode_chk.sv
      - testbench/tb_pcs_rx_decode.sv
